// File: pciedma_slv.f
pcie_bar_pkg.sv
slv_map_pkg.sv
slv_bar_ctrl.sv
bar0_regs.sv
bar2_ram.sv
pciedma_slv.sv
tb_pciedma_slv.sv

// File: Bender.yml
package:
  name: pciedma_slv

dependencies: {}

sources:
  - pcie_bar_pkg.sv
  - slv_map_pkg.sv
  - slv_bar_ctrl.sv
  - bar0_regs.sv
  - bar2_ram.sv
  - pciedma_slv.sv
  - target: test
    files:
      - tb_pciedma_slv.sv

// File: tb_pciedma_slv.sv
`timescale 1ns/1ns

module tb_pciedma_slv;

	localparam logic [31:0] SEED = 32'h269a_5878;
	localparam logic [6:0] HIT_REGS = 7'b000_0001;
	localparam logic [6:0] HIT_RAM = 7'b000_0100;
	localparam int N_REG_WR = 8;
	localparam int N_RAM = 8;
	// Transfers per test: reset reads, reg write/read pairs, RAM, switch/echo, errors
	localparam int NUM_XFERS = 2 + 2 * N_REG_WR + 4 * N_RAM + 5 + 5;
	localparam int TIMEOUT_NS = (NUM_XFERS * 4 + 3 + 40) * 40;

	logic pcie_clk;
	logic sys_rst;
	logic psel_i;
	logic penable_i;
	logic pwrite_i;
	logic [19:0] paddr_i;
	logic [15:0] pwdata_i;
	logic [1:0] pstrb_i;
	logic [6:0] bar_hit_i;
	logic [7:0] dipsw_i;
	logic [15:0] prdata_o;
	logic pready_o;
	logic pslverr_o;
	logic [13:0] segled_o;
	logic [7:0] led_o;

	// Reference model
	logic [13:0] seg_m;
	logic [7:0] led_m;
	logic [15:0] ram_m [int];
	logic exp_err;
	logic [15:0] exp_rdata;

	int err_cnt;
	int err_mark;
	int pass_cnt;
	int fail_cnt;

	pciedma_slv dut0 (
		.pcie_clk(pcie_clk),
		.sys_rst(sys_rst),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.pstrb_i(pstrb_i),
		.bar_hit_i(bar_hit_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.dipsw_i(dipsw_i),
		.segled_o(segled_o),
		.led_o(led_o)
	);

	always #20 pcie_clk = ~pcie_clk;

	function automatic logic [15:0] model_read(input logic [6:0] hit, input logic [19:0] addr);
		logic [8:0] idx;
		logic [13:0] word;
		idx = addr[9:1];
		word = addr[14:1];
		if (hit[2])
			return ram_m[word];
		case (idx)
			9'd0: return {2'b00, seg_m};
			9'd1: return {8'h00, led_m};
			9'd2: return {8'h00, dipsw_i};
			default: return addr[16:1];
		endcase
	endfunction

	function automatic void model_write(input logic [6:0] hit, input logic [19:0] addr,
		input logic [15:0] d, input logic [1:0] strb);
		logic [15:0] old;
		logic [13:0] word;
		word = addr[14:1];
		if (hit[2]) begin
			old = ram_m.exists(word) ? ram_m[word] : 16'h0000;
			if (strb[0])
				old[7:0] = d[7:0];
			if (strb[1])
				old[15:8] = d[15:8];
			ram_m[word] = old;
		end else if (addr[9:1] == 9'd0) begin
			if (strb[0])
				seg_m[7:0] = d[7:0];
			if (strb[1])
				seg_m[13:8] = d[13:8];
		end else if (addr[9:1] == 9'd1 && strb[0]) begin
			led_m = d[7:0];
		end
	endfunction

	task automatic apb_xfer(input logic wr, input logic [6:0] hit, input logic [19:0] addr,
		input logic [15:0] wdata, input logic [1:0] strb);
		@(posedge pcie_clk);
		exp_err = !(hit[0] ^ hit[2]);
		exp_rdata = (exp_err || wr) ? 16'h0000 : model_read(hit, addr);
		psel_i <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i <= wr;
		paddr_i <= addr;
		pwdata_i <= wdata;
		pstrb_i <= strb;
		bar_hit_i <= hit;
		@(posedge pcie_clk);
		penable_i <= 1'b1;
		do
			@(posedge pcie_clk);
		while (!pready_o);
		psel_i <= 1'b0;
		penable_i <= 1'b0;
		if (wr && !exp_err)
			model_write(hit, addr, wdata, strb);
	endtask

	// Lets the last checks of a test settle before counting
	task automatic end_test(input string name);
		repeat (2) @(posedge pcie_clk);
		if (err_cnt == err_mark) begin
			pass_cnt++;
			$display("test %s: pass", name);
		end else begin
			fail_cnt++;
			$display("test %s: fail with %0d errors", name, err_cnt - err_mark);
		end
		err_mark = err_cnt;
	endtask

	a_err_flag: assert property (
		@(posedge pcie_clk) disable iff (sys_rst)
		pready_o |-> (pslverr_o == exp_err)
	) else begin
		err_cnt++;
		$display("mismatch at %0t: pslverr %b, expected %b", $time, $sampled(pslverr_o),
			$sampled(exp_err));
	end

	a_rdata: assert property (
		@(posedge pcie_clk) disable iff (sys_rst)
		(pready_o && (!pwrite_i || exp_err)) |-> (prdata_o == exp_rdata)
	) else begin
		err_cnt++;
		$display("mismatch at %0t: read data %h, expected %h", $time, $sampled(prdata_o),
			$sampled(exp_rdata));
	end

	a_board_out: assert property (
		@(posedge pcie_clk) disable iff (sys_rst)
		!psel_i |-> (segled_o == seg_m && led_o == led_m)
	) else begin
		err_cnt++;
		$display("mismatch at %0t: segled %h led %h, expected %h %h", $time,
			$sampled(segled_o), $sampled(led_o), $sampled(seg_m), $sampled(led_m));
	end

	// Two access cycles for a valid BAR, one for an error
	a_lat_ok: assert property (
		@(posedge pcie_clk) disable iff (sys_rst)
		($rose(penable_i) && !exp_err) |-> (!pready_o ##1 pready_o)
	) else begin
		err_cnt++;
		$display("at %0t pready did not rise in the second access cycle", $time);
	end

	a_lat_err: assert property (
		@(posedge pcie_clk) disable iff (sys_rst)
		($rose(penable_i) && exp_err) |-> pready_o
	) else begin
		err_cnt++;
		$display("at %0t pready did not rise in the first access cycle of an error", $time);
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		logic [8:0] idx;
		logic [1:0] strb;
		logic [31:0] rnd;
		logic [13:0] words [N_RAM];
		logic [13:0] w;
		void'($urandom(SEED));
		pcie_clk = 1'b0;
		sys_rst = 1'b1;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = '0;
		pwdata_i = '0;
		pstrb_i = '0;
		bar_hit_i = '0;
		dipsw_i = $urandom;
		seg_m = 14'h3fff;
		led_m = 8'h00;
		exp_err = 1'b0;
		exp_rdata = '0;
		err_cnt = 0;
		err_mark = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		repeat (3) @(posedge pcie_clk);
		sys_rst <= 1'b0;

		apb_xfer(1'b0, HIT_REGS, 20'h00000, 16'h0, 2'b00);
		apb_xfer(1'b0, HIT_REGS, 20'h00002, 16'h0, 2'b00);
		end_test("reset values");

		for (int i = 0; i < N_REG_WR; i++) begin
			idx = $urandom_range(1, 0);
			strb = $urandom_range(3, 1);
			apb_xfer(1'b1, HIT_REGS, {10'h000, idx, 1'b0}, $urandom, strb);
			apb_xfer(1'b0, HIT_REGS, {10'h000, idx, 1'b0}, 16'h0, 2'b00);
		end
		end_test("segment and led writes");

		// Full words first so no byte of a checked word is left unwritten
		for (int i = 0; i < N_RAM; i++) begin
			words[i] = $urandom_range(16383, 0);
			apb_xfer(1'b1, HIT_RAM, {5'h00, words[i], 1'b0}, $urandom, 2'b11);
		end
		for (int i = 0; i < 2 * N_RAM; i++) begin
			w = words[$urandom_range(N_RAM - 1, 0)];
			apb_xfer(1'b1, HIT_RAM, {5'h00, w, 1'b0}, $urandom, $urandom_range(3, 0));
		end
		for (int i = 0; i < N_RAM; i++)
			apb_xfer(1'b0, HIT_RAM, {5'h00, words[i], 1'b0}, 16'h0, 2'b00);
		end_test("ram byte writes");

		apb_xfer(1'b0, HIT_REGS, {10'h000, 9'd2, 1'b0}, 16'h0, 2'b00);
		for (int i = 0; i < 4; i++) begin
			idx = $urandom_range(511, 3);
			rnd = $urandom;
			apb_xfer(1'b0, HIT_REGS, {rnd[9:0], idx, 1'b0}, 16'h0, 2'b00);
		end
		end_test("switches and unmapped echo");

		apb_xfer(1'b1, 7'b000_0000, 20'h00000, 16'h1234, 2'b11);
		apb_xfer(1'b1, 7'b000_0101, 20'h00000, 16'h0a5a, 2'b11);
		apb_xfer(1'b1, 7'b000_0010, {5'h00, words[0], 1'b0}, 16'hbeef, 2'b11);
		apb_xfer(1'b0, HIT_REGS, 20'h00000, 16'h0, 2'b00);
		apb_xfer(1'b0, HIT_RAM, {5'h00, words[0], 1'b0}, 16'h0, 2'b00);
		end_test("invalid bar hits");

		$display("tests passed: %0d, failed: %0d, check errors: %0d", pass_cnt, fail_cnt,
			err_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: pciedma_slv.sv
`timescale 1ns/1ns

module pciedma_slv (
	input logic pcie_clk,
	input logic sys_rst,
	// APB from the TLP decoder
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [pcie_bar_pkg::ADDR_W-1:0] paddr_i,
	input logic [pcie_bar_pkg::DATA_W-1:0] pwdata_i,
	input logic [pcie_bar_pkg::STRB_W-1:0] pstrb_i,
	input logic [pcie_bar_pkg::BAR_NUM-1:0] bar_hit_i,
	output logic [pcie_bar_pkg::DATA_W-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	// Board I/O
	input logic [slv_map_pkg::DIPSW_W-1:0] dipsw_i,
	output logic [slv_map_pkg::SEGLED_W-1:0] segled_o,
	output logic [slv_map_pkg::LED_W-1:0] led_o
);

	logic regs_ce;
	logic ram_ce;
	logic slv_we;
	logic [pcie_bar_pkg::STRB_W-1:0] slv_sel;
	slv_map_pkg::slv_addr_u slv_adr;
	logic [pcie_bar_pkg::DATA_W-1:0] slv_dat;
	logic [pcie_bar_pkg::DATA_W-1:0] regs_dat;
	logic [pcie_bar_pkg::DATA_W-1:0] ram_dat;

	slv_bar_ctrl ctrl0 (
		.pcie_clk(pcie_clk),
		.sys_rst(sys_rst),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.pstrb_i(pstrb_i),
		.bar_hit_i(bar_hit_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.regs_dat_i(regs_dat),
		.ram_dat_i(ram_dat),
		.regs_ce_o(regs_ce),
		.ram_ce_o(ram_ce),
		.slv_we_o(slv_we),
		.slv_sel_o(slv_sel),
		.slv_adr_o(slv_adr),
		.slv_dat_o(slv_dat)
	);

	// BAR0
	bar0_regs regs0 (
		.pcie_clk(pcie_clk),
		.sys_rst(sys_rst),
		.ce_i(regs_ce),
		.we_i(slv_we),
		.sel_i(slv_sel),
		.adr_i(slv_adr),
		.dat_i(slv_dat),
		.dipsw_i(dipsw_i),
		.dat_o(regs_dat),
		.segled_o(segled_o),
		.led_o(led_o)
	);

	// BAR2
	bar2_ram ram0 (
		.pcie_clk(pcie_clk),
		.sys_rst(sys_rst),
		.ce_i(ram_ce),
		.we_i(slv_we),
		.sel_i(slv_sel),
		.adr_i(slv_adr),
		.dat_i(slv_dat),
		.dat_o(ram_dat)
	);

endmodule

// File: bar2_ram.sv
`timescale 1ns/1ns

module bar2_ram (
	input logic pcie_clk,
	input logic sys_rst,
	input logic ce_i,
	input logic we_i,
	input logic [pcie_bar_pkg::STRB_W-1:0] sel_i,
	input slv_map_pkg::slv_addr_u adr_i,
	input logic [pcie_bar_pkg::DATA_W-1:0] dat_i,
	output logic [pcie_bar_pkg::DATA_W-1:0] dat_o
);

	logic [pcie_bar_pkg::DATA_W-1:0] mem [slv_map_pkg::RAM_DEPTH];
	logic [slv_map_pkg::RAM_AW-1:0] waddr;

	assign waddr = adr_i.ram.word;

	// Byte-lane writes
	always_ff @(posedge pcie_clk) begin
		if (ce_i && we_i) begin
			for (int b = 0; b < pcie_bar_pkg::STRB_W; b++) begin
				if (sel_i[b])
					mem[waddr][b*pcie_bar_pkg::BYTE_W +: pcie_bar_pkg::BYTE_W] <=
						dat_i[b*pcie_bar_pkg::BYTE_W +: pcie_bar_pkg::BYTE_W];
			end
		end
	end

	// Registered read port, only a read strobe updates it
	always_ff @(posedge pcie_clk) begin
		if (sys_rst)
			dat_o <= '0;
		else if (ce_i && !we_i)
			dat_o <= mem[waddr];
	end

	// Offsets beyond the RAM would wrap onto low words
	a_no_alias: assert property (
		@(posedge pcie_clk) disable iff (sys_rst)
		ce_i |-> (adr_i.ram.upper == '0)
	) else $error("BAR2 access above the RAM at word %h", adr_i);

endmodule

// File: bar0_regs.sv
`timescale 1ns/1ns

module bar0_regs (
	input logic pcie_clk,
	input logic sys_rst,
	input logic ce_i,
	input logic we_i,
	input logic [pcie_bar_pkg::STRB_W-1:0] sel_i,
	input slv_map_pkg::slv_addr_u adr_i,
	input logic [pcie_bar_pkg::DATA_W-1:0] dat_i,
	input logic [slv_map_pkg::DIPSW_W-1:0] dipsw_i,
	output logic [pcie_bar_pkg::DATA_W-1:0] dat_o,
	output logic [slv_map_pkg::SEGLED_W-1:0] segled_o,
	output logic [slv_map_pkg::LED_W-1:0] led_o
);

	logic [slv_map_pkg::SEGLED_W-1:0] segled_q;
	logic [slv_map_pkg::LED_W-1:0] led_q;
	logic [pcie_bar_pkg::DATA_W-1:0] rd_q;

	// Register writes, byte lanes follow the strobes
	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			segled_q <= slv_map_pkg::SEGLED_RST;
			led_q <= slv_map_pkg::LED_RST;
		end else if (ce_i && we_i) begin
			case (adr_i.regs.idx)
				slv_map_pkg::REG_SEGLED: begin
					if (sel_i[0])
						segled_q[pcie_bar_pkg::BYTE_W-1:0] <= dat_i[pcie_bar_pkg::BYTE_W-1:0];
					if (sel_i[1])
						segled_q[slv_map_pkg::SEGLED_W-1:pcie_bar_pkg::BYTE_W] <=
							dat_i[slv_map_pkg::SEGLED_W-1:pcie_bar_pkg::BYTE_W];
				end
				slv_map_pkg::REG_LED: begin
					// Only the low lane is backed
					if (sel_i[0])
						led_q <= dat_i[slv_map_pkg::LED_W-1:0];
				end
				default: ;
			endcase
		end
	end

	// Read data captured on the strobe, held until the next read
	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			rd_q <= '0;
		end else if (ce_i && !we_i) begin
			case (adr_i.regs.idx)
				slv_map_pkg::REG_SEGLED:
					rd_q <= {{(pcie_bar_pkg::DATA_W - slv_map_pkg::SEGLED_W){1'b0}}, segled_q};
				slv_map_pkg::REG_LED:
					rd_q <= {{(pcie_bar_pkg::DATA_W - slv_map_pkg::LED_W){1'b0}}, led_q};
				slv_map_pkg::REG_DIPSW:
					rd_q <= {{(pcie_bar_pkg::DATA_W - slv_map_pkg::DIPSW_W){1'b0}}, dipsw_i};
				// Unmapped offsets echo byte address bits 16:1
				default: rd_q <= adr_i[pcie_bar_pkg::DATA_W-1:0];
			endcase
		end
	end

	assign dat_o = rd_q;
	assign segled_o = segled_q;
	assign led_o = led_q;

	a_wr_has_strobe: assert property (
		@(posedge pcie_clk) disable iff (sys_rst)
		(ce_i && we_i) |-> (sel_i != '0)
	) else $error("BAR0 write with no byte enable");

endmodule

// File: slv_bar_ctrl.sv
`timescale 1ns/1ns

module slv_bar_ctrl (
	input logic pcie_clk,
	input logic sys_rst,
	// APB slave
	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input logic [pcie_bar_pkg::ADDR_W-1:0] paddr_i,
	input logic [pcie_bar_pkg::DATA_W-1:0] pwdata_i,
	input logic [pcie_bar_pkg::STRB_W-1:0] pstrb_i,
	input logic [pcie_bar_pkg::BAR_NUM-1:0] bar_hit_i,
	output logic [pcie_bar_pkg::DATA_W-1:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	// Datapath blocks
	input logic [pcie_bar_pkg::DATA_W-1:0] regs_dat_i,
	input logic [pcie_bar_pkg::DATA_W-1:0] ram_dat_i,
	output logic regs_ce_o,
	output logic ram_ce_o,
	output logic slv_we_o,
	output logic [pcie_bar_pkg::STRB_W-1:0] slv_sel_o,
	output slv_map_pkg::slv_addr_u slv_adr_o,
	output logic [pcie_bar_pkg::DATA_W-1:0] slv_dat_o
);

	logic [pcie_bar_pkg::ST_W-1:0] state;
	logic hit_regs;
	logic hit_ram;
	logic bar_ok;
	logic hit_regs_q;
	logic hit_ram_q;
	logic err_q;

	// Exactly one of BAR0 and BAR2 must be hit
	assign hit_regs = bar_hit_i[pcie_bar_pkg::BAR_REGS];
	assign hit_ram = bar_hit_i[pcie_bar_pkg::BAR_RAM];
	assign bar_ok = hit_regs ^ hit_ram;

	// Strobe or error decided in the setup cycle
	always_ff @(posedge pcie_clk) begin
		if (sys_rst) begin
			state <= pcie_bar_pkg::ST_IDLE;
			hit_regs_q <= 1'b0;
			hit_ram_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			case (state)
				pcie_bar_pkg::ST_IDLE: begin
					if (psel_i && !penable_i) begin
						hit_regs_q <= hit_regs;
						hit_ram_q <= hit_ram;
						err_q <= !bar_ok;
						state <= bar_ok ? pcie_bar_pkg::ST_STROBE : pcie_bar_pkg::ST_RESP;
					end
				end
				pcie_bar_pkg::ST_STROBE: state <= pcie_bar_pkg::ST_RESP;
				pcie_bar_pkg::ST_RESP: state <= pcie_bar_pkg::ST_IDLE;
				default: state <= pcie_bar_pkg::ST_IDLE;
			endcase
		end
	end

	// One-cycle strobe in the first access cycle
	assign regs_ce_o = (state == pcie_bar_pkg::ST_STROBE) && hit_regs_q;
	assign ram_ce_o = (state == pcie_bar_pkg::ST_STROBE) && hit_ram_q;

	// Payload is held stable by the host for the whole transfer
	assign slv_we_o = pwrite_i;
	assign slv_sel_o = pstrb_i;
	assign slv_adr_o = paddr_i[pcie_bar_pkg::ADDR_W-1:1];
	assign slv_dat_o = pwdata_i;

	assign pready_o = (state == pcie_bar_pkg::ST_RESP);
	assign pslverr_o = (state == pcie_bar_pkg::ST_RESP) && err_q;

	// Blocks return registered data in the respond cycle
	always_comb begin
		prdata_o = '0;
		if (state == pcie_bar_pkg::ST_RESP && !err_q)
			prdata_o = hit_regs_q ? regs_dat_i : ram_dat_i;
	end

	a_ce_in_access: assert property (
		@(posedge pcie_clk) disable iff (sys_rst)
		(regs_ce_o || ram_ce_o) |-> (psel_i && penable_i)
	) else $error("slave strobe outside an APB access cycle");

	a_ce_exclusive: assert property (
		@(posedge pcie_clk) disable iff (sys_rst)
		!(regs_ce_o && ram_ce_o)
	) else $error("BAR0 and BAR2 strobes high together");

	a_ready_in_access: assert property (
		@(posedge pcie_clk) disable iff (sys_rst)
		pready_o |-> (psel_i && penable_i)
	) else $error("pready outside an APB access cycle");

endmodule

// File: slv_map_pkg.sv
package slv_map_pkg;

	// Word address seen by the datapath blocks
	localparam int WADDR_W = pcie_bar_pkg::ADDR_W - 1;

	// BAR0 register map
	localparam int REG_IDX_W = 9;
	localparam logic [REG_IDX_W-1:0] REG_SEGLED = 9'd0;
	localparam logic [REG_IDX_W-1:0] REG_LED = 9'd1;
	localparam logic [REG_IDX_W-1:0] REG_DIPSW = 9'd2;

	// Board I/O widths
	localparam int SEGLED_W = 14;
	localparam int LED_W = 8;
	localparam int DIPSW_W = 8;

	// Segments start blank, the pattern is active low
	localparam logic [SEGLED_W-1:0] SEGLED_RST = 14'h3fff;
	localparam logic [LED_W-1:0] LED_RST = 8'h00;

	// BAR2 RAM geometry
	localparam int RAM_AW = 14;
	localparam int RAM_DEPTH = 1 << RAM_AW;

	// One word address, two decodes
	// regs: register index in the low bits, rest is don't care
	// ram: word address in the low bits, upper bits must stay zero
	typedef union packed {
		struct packed {
			logic [WADDR_W-REG_IDX_W-1:0] upper;
			logic [REG_IDX_W-1:0] idx;
		} regs;
		struct packed {
			logic [WADDR_W-RAM_AW-1:0] upper;
			logic [RAM_AW-1:0] word;
		} ram;
	} slv_addr_u;

endpackage

// File: pcie_bar_pkg.sv
package pcie_bar_pkg;

	// BAR-hit vector as delivered with each decoded TLP
	localparam int BAR_NUM = 7;

	// Hit bit positions of the two BARs this target answers
	localparam int BAR_REGS = 0;
	localparam int BAR_RAM = 2;

	// Slave data path
	localparam int DATA_W = 16;
	localparam int STRB_W = 2;
	localparam int BYTE_W = DATA_W / STRB_W;

	// APB byte address, bit 0 is always dropped on the slave side
	localparam int ADDR_W = 20;

	// Access sequence of the slave controller
	localparam int ST_W = 2;
	localparam logic [ST_W-1:0] ST_IDLE = 2'd0;
	localparam logic [ST_W-1:0] ST_STROBE = 2'd1;
	localparam logic [ST_W-1:0] ST_RESP = 2'd2;

endpackage
